// ==== hw/mem_banked_consts.svh ====
// Sizes are fixed at compile time and MB_ADDR_W must equal row bits plus bank bits plus byte bits
`ifndef MEM_BANKED_CONSTS_SVH
`define MEM_BANKED_CONSTS_SVH

// Bus word and bank word are the same width
`define MB_DATA_W 32
// Byte address on the bus
`define MB_ADDR_W 12
`define MB_ID_W 4
// Power of two so the bank field is a plain bit slice
`define MB_NUM_BANKS 4
// 8 row bits, 2 bank bits and 2 byte bits cover the full 12-bit space
`define MB_BANK_ROWS_W 8
// Bank read latency in cycles, at least 1
`define MB_MEM_LAT 1

// Derived sizes
`define MB_STRB_W (`MB_DATA_W / 8)
`define MB_OFF_W $clog2(`MB_STRB_W)
`define MB_BANK_SEL_W $clog2(`MB_NUM_BANKS)

`endif

// ==== hw/mem_bus_pkg.sv ====
// Single-beat bus channels only; no error field since every address maps to a bank word
`default_nettype none

`include "mem_banked_consts.svh"

package mem_bus_pkg;

  // Write request with payload and byte strobe
  typedef struct packed {
    logic [`MB_ADDR_W-1:0] addr;
    logic [`MB_ID_W-1:0]   id;
    logic [`MB_DATA_W-1:0] data;
    logic [`MB_STRB_W-1:0] strb;
  } bus_wreq_t;

  // Write response carries the ID back
  typedef struct packed {
    logic [`MB_ID_W-1:0] id;
  } bus_wrsp_t;

  typedef struct packed {
    logic [`MB_ADDR_W-1:0] addr;
    logic [`MB_ID_W-1:0]   id;
  } bus_rreq_t;

  // Read response with returned word
  typedef struct packed {
    logic [`MB_ID_W-1:0]   id;
    logic [`MB_DATA_W-1:0] data;
  } bus_rrsp_t;

endpackage

`default_nettype wire

// ==== hw/mem_bank_pkg.sv ====
// Bank-side types for word-interleaved banks; the address split assumes MB_NUM_BANKS is a power of two
`default_nettype none

`include "mem_banked_consts.svh"

package mem_bank_pkg;

  typedef logic [`MB_BANK_SEL_W-1:0] bank_sel_t;

  // Byte address split, lowest bits pick the byte
  // Next bits pick the bank so that consecutive words interleave
  typedef struct packed {
    logic [`MB_BANK_ROWS_W-1:0] row;
    bank_sel_t                  bank;
    logic [`MB_OFF_W-1:0]       off;
  } mem_addr_fields_t;

  // Raw view written by the port controller
  // Field view read by the crossbar
  typedef union packed {
    logic [`MB_ADDR_W-1:0] raw;
    mem_addr_fields_t      f;
  } mem_addr_u;

  // One single-word bank access
  typedef struct packed {
    mem_addr_u             addr;
    logic                  we;
    logic [`MB_DATA_W-1:0] wdata;
    logic [`MB_STRB_W-1:0] strb;
  } bank_req_t;

  // Port controller states
  // Also decoded by the bound properties
  typedef enum logic [1:0] {
    st_idle      = 2'd0,
    st_request   = 2'd1,
    st_wait_data = 2'd2,
    st_respond   = 2'd3
  } port_state_e;

endpackage

`default_nettype wire

// ==== hw/bus_port_ctrl.sv ====
// One outstanding transaction per port; IsWrite fixes the direction and a read port ignores data and strobe
`timescale 1ns/1ns
`default_nettype none

`include "mem_banked_consts.svh"

module bus_port_ctrl #(
  parameter bit IsWrite = 1'b1
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Bus request side
  input  mem_bus_pkg::bus_wreq_t   wreq_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  // Bus response side
  output mem_bus_pkg::bus_rrsp_t   rsp_o,
  output logic                     rsp_valid_o,
  input  logic                     rsp_ready_i,
  // Crossbar side
  output mem_bank_pkg::bank_req_t  bank_req_o,
  output logic                     bank_valid_o,
  input  logic                     gnt_i,
  input  logic                     rvalid_i,
  input  logic [`MB_DATA_W-1:0]    rdata_i,
  output logic                     busy_o
);
  import mem_bank_pkg::*;

  port_state_e           state_q;
  port_state_e           state_d;
  bank_req_t             req_q;
  logic [`MB_ID_W-1:0]   id_q;
  logic [`MB_DATA_W-1:0] rdata_q;

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      st_idle: begin
        if (req_valid_i) begin
          state_d = st_request;
        end
      end
      st_request: begin
        // Writes finish at the grant edge, reads still wait for data
        if (gnt_i) begin
          state_d = IsWrite ? st_respond : st_wait_data;
        end
      end
      st_wait_data: begin
        if (rvalid_i) begin
          state_d = st_respond;
        end
      end
      st_respond: begin
        if (rsp_ready_i) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload capture on accept
  // Held unchanged until the response is taken
  always_ff @(posedge clk_i) begin
    if (state_q == st_idle && req_valid_i) begin
      req_q.addr.raw <= wreq_i.addr;
      req_q.we       <= IsWrite;
      req_q.wdata    <= wreq_i.data;
      req_q.strb     <= wreq_i.strb;
      id_q           <= wreq_i.id;
    end
    // Read word arrives once per read
    if (state_q == st_wait_data && rvalid_i) begin
      rdata_q <= rdata_i;
    end
  end

  // Only idle takes a new request
  assign req_ready_o  = (state_q == st_idle);
  assign bank_valid_o = (state_q == st_request);
  assign bank_req_o   = req_q;
  assign rsp_valid_o  = (state_q == st_respond);
  assign busy_o       = (state_q != st_idle);

  // Write responses carry no data
  assign rsp_o.id   = id_q;
  assign rsp_o.data = IsWrite ? '0 : rdata_q;

endmodule

`default_nettype wire

// ==== hw/read_latency_tracker.sv ====
// Fixed delay of MB_MEM_LAT cycles; must match the bank read pipeline exactly
`timescale 1ns/1ns
`default_nettype none

`include "mem_banked_consts.svh"

module read_latency_tracker (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    grant_i,
  input  mem_bank_pkg::bank_sel_t bank_i,
  output logic                    rvalid_o,
  output mem_bank_pkg::bank_sel_t bank_o
);
  import mem_bank_pkg::*;

  // One stage per cycle of bank latency
  logic [`MB_MEM_LAT-1:0]            vld_q;
  bank_sel_t [`MB_MEM_LAT-1:0]       bank_q;

  // Valid line is control state
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= grant_i;
      for (int unsigned i = 1; i < `MB_MEM_LAT; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // Bank index rides alongside
  always_ff @(posedge clk_i) begin
    bank_q[0] <= bank_i;
    for (int unsigned i = 1; i < `MB_MEM_LAT; i++) begin
      bank_q[i] <= bank_q[i-1];
    end
  end

  assign rvalid_o = vld_q[`MB_MEM_LAT-1];
  assign bank_o   = bank_q[`MB_MEM_LAT-1];

endmodule

`default_nettype wire

// ==== hw/bank_xbar.sv ====
// Two ports to all banks; same-bank conflicts alternate per bank and the loser must keep its request
`timescale 1ns/1ns
`default_nettype none

`include "mem_banked_consts.svh"

module bank_xbar (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // Port 0 is the write port
  input  mem_bank_pkg::bank_req_t                       wr_req_i,
  input  logic                                          wr_valid_i,
  output logic                                          wr_gnt_o,
  // Port 1 is the read port
  input  mem_bank_pkg::bank_req_t                       rd_req_i,
  input  logic                                          rd_valid_i,
  output logic                                          rd_gnt_o,
  output mem_bank_pkg::bank_sel_t                       rd_gnt_bank_o,
  // Bank side
  output logic [`MB_NUM_BANKS-1:0]                      bank_en_o,
  output logic [`MB_NUM_BANKS-1:0]                      bank_we_o,
  output logic [`MB_NUM_BANKS-1:0][`MB_BANK_ROWS_W-1:0] bank_row_o,
  output logic [`MB_NUM_BANKS-1:0][`MB_DATA_W-1:0]      bank_wdata_o,
  output logic [`MB_NUM_BANKS-1:0][`MB_STRB_W-1:0]      bank_strb_o,
  input  logic [`MB_NUM_BANKS-1:0][`MB_DATA_W-1:0]      bank_rdata_i,
  // Read data return
  input  mem_bank_pkg::bank_sel_t                       ret_bank_i,
  output logic [`MB_DATA_W-1:0]                         rdata_o
);
  import mem_bank_pkg::*;

  bank_sel_t                wr_bank;
  bank_sel_t                rd_bank;
  logic                     conflict;
  // Per-bank priority, set means the read port wins
  logic [`MB_NUM_BANKS-1:0] prio_q;

  // Decode the bank field of each address
  assign wr_bank  = wr_req_i.addr.f.bank;
  assign rd_bank  = rd_req_i.addr.f.bank;
  assign conflict = wr_valid_i && rd_valid_i && (wr_bank == rd_bank);

  assign wr_gnt_o      = wr_valid_i && (!conflict || !prio_q[wr_bank]);
  assign rd_gnt_o      = rd_valid_i && (!conflict || prio_q[rd_bank]);
  assign rd_gnt_bank_o = rd_bank;

  // Flip priority of a bank after each conflict on it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_q <= '0;
    end else if (conflict) begin
      prio_q[wr_bank] <= ~prio_q[wr_bank];
    end
  end

  // Drive each bank from its winning port
  for (genvar b = 0; b < `MB_NUM_BANKS; b++) begin : gen_bank_route
    logic      wr_sel;
    logic      rd_sel;
    bank_req_t win_req;

    assign wr_sel  = wr_gnt_o && (wr_bank == bank_sel_t'(b));
    assign rd_sel  = rd_gnt_o && (rd_bank == bank_sel_t'(b));
    assign win_req = rd_sel ? rd_req_i : wr_req_i;

    assign bank_en_o[b]    = wr_sel || rd_sel;
    assign bank_we_o[b]    = wr_sel && win_req.we;
    assign bank_row_o[b]   = win_req.addr.f.row;
    assign bank_wdata_o[b] = win_req.wdata;
    assign bank_strb_o[b]  = win_req.strb;
  end

  // Bank picked by the latency tracker
  assign rdata_o = bank_rdata_i[ret_bank_i];

endmodule

`default_nettype wire

// ==== hw/sram_bank.sv ====
// Behavioral model for simulation; memory content is not reset and read data holds between reads
`timescale 1ns/1ns
`default_nettype none

`include "mem_banked_consts.svh"

module sram_bank (
  input  logic                       clk_i,
  input  logic                       en_i,
  input  logic                       we_i,
  input  logic [`MB_BANK_ROWS_W-1:0] row_i,
  input  logic [`MB_DATA_W-1:0]      wdata_i,
  input  logic [`MB_STRB_W-1:0]      strb_i,
  output logic [`MB_DATA_W-1:0]      rdata_o
);

  logic [`MB_DATA_W-1:0]                  mem_q [2**`MB_BANK_ROWS_W];
  // Read pipeline with one stage per latency cycle
  logic [`MB_MEM_LAT-1:0][`MB_DATA_W-1:0] rd_pipe_q;

  // Byte-strobed write
  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      for (int unsigned i = 0; i < `MB_STRB_W; i++) begin
        if (strb_i[i]) begin
          mem_q[row_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // First stage samples the array
  always_ff @(posedge clk_i) begin
    if (en_i && !we_i) begin
      rd_pipe_q[0] <= mem_q[row_i];
    end
    for (int unsigned i = 1; i < `MB_MEM_LAT; i++) begin
      rd_pipe_q[i] <= rd_pipe_q[i-1];
    end
  end

  assign rdata_o = rd_pipe_q[`MB_MEM_LAT-1];

endmodule

`default_nettype wire

// ==== hw/mem_banked_top.sv ====
// Reads and writes are served in parallel with one outstanding transaction each and single-beat only
`timescale 1ns/1ns
`default_nettype none

`include "mem_banked_consts.svh"

module mem_banked_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Write channels
  input  mem_bus_pkg::bus_wreq_t wreq_i,
  input  logic                   wreq_valid_i,
  output logic                   wreq_ready_o,
  output mem_bus_pkg::bus_wrsp_t wrsp_o,
  output logic                   wrsp_valid_o,
  input  logic                   wrsp_ready_i,
  // Read channels
  input  mem_bus_pkg::bus_rreq_t rreq_i,
  input  logic                   rreq_valid_i,
  output logic                   rreq_ready_o,
  output mem_bus_pkg::bus_rrsp_t rrsp_o,
  output logic                   rrsp_valid_o,
  input  logic                   rrsp_ready_i,
  // Bit 0 write port, bit 1 read port
  output logic [1:0]             busy_o
);
  import mem_bus_pkg::*;
  import mem_bank_pkg::*;

  bus_wreq_t rd_wreq;
  bus_rrsp_t wr_rsp;
  bank_req_t wr_bank_req;
  bank_req_t rd_bank_req;
  logic      wr_bank_valid;
  logic      rd_bank_valid;
  logic      wr_gnt;
  logic      rd_gnt;
  bank_sel_t rd_gnt_bank;
  bank_sel_t ret_bank;
  logic      rd_rvalid;
  logic [`MB_DATA_W-1:0] rd_rdata;

  logic [`MB_NUM_BANKS-1:0]                      bank_en;
  logic [`MB_NUM_BANKS-1:0]                      bank_we;
  logic [`MB_NUM_BANKS-1:0][`MB_BANK_ROWS_W-1:0] bank_row;
  logic [`MB_NUM_BANKS-1:0][`MB_DATA_W-1:0]      bank_wdata;
  logic [`MB_NUM_BANKS-1:0][`MB_STRB_W-1:0]      bank_strb;
  logic [`MB_NUM_BANKS-1:0][`MB_DATA_W-1:0]      bank_rdata;

  // Read request widened to the shared payload
  assign rd_wreq = '{addr: rreq_i.addr, id: rreq_i.id, data: '0, strb: '0};
  assign wrsp_o  = '{id: wr_rsp.id};

  bus_port_ctrl #(
    .IsWrite ( 1'b1 )
  ) i_wr_port (
    .clk_i,
    .rst_n_i,
    .wreq_i       ( wreq_i        ),
    .req_valid_i  ( wreq_valid_i  ),
    .req_ready_o  ( wreq_ready_o  ),
    .rsp_o        ( wr_rsp        ),
    .rsp_valid_o  ( wrsp_valid_o  ),
    .rsp_ready_i  ( wrsp_ready_i  ),
    .bank_req_o   ( wr_bank_req   ),
    .bank_valid_o ( wr_bank_valid ),
    .gnt_i        ( wr_gnt        ),
    .rvalid_i     ( 1'b0          ),
    .rdata_i      ( '0            ),
    .busy_o       ( busy_o[0]     )
  );

  bus_port_ctrl #(
    .IsWrite ( 1'b0 )
  ) i_rd_port (
    .clk_i,
    .rst_n_i,
    .wreq_i       ( rd_wreq       ),
    .req_valid_i  ( rreq_valid_i  ),
    .req_ready_o  ( rreq_ready_o  ),
    .rsp_o        ( rrsp_o        ),
    .rsp_valid_o  ( rrsp_valid_o  ),
    .rsp_ready_i  ( rrsp_ready_i  ),
    .bank_req_o   ( rd_bank_req   ),
    .bank_valid_o ( rd_bank_valid ),
    .gnt_i        ( rd_gnt        ),
    .rvalid_i     ( rd_rvalid     ),
    .rdata_i      ( rd_rdata      ),
    .busy_o       ( busy_o[1]     )
  );

  bank_xbar i_bank_xbar (
    .clk_i,
    .rst_n_i,
    .wr_req_i      ( wr_bank_req   ),
    .wr_valid_i    ( wr_bank_valid ),
    .wr_gnt_o      ( wr_gnt        ),
    .rd_req_i      ( rd_bank_req   ),
    .rd_valid_i    ( rd_bank_valid ),
    .rd_gnt_o      ( rd_gnt        ),
    .rd_gnt_bank_o ( rd_gnt_bank   ),
    .bank_en_o     ( bank_en       ),
    .bank_we_o     ( bank_we       ),
    .bank_row_o    ( bank_row      ),
    .bank_wdata_o  ( bank_wdata    ),
    .bank_strb_o   ( bank_strb     ),
    .bank_rdata_i  ( bank_rdata    ),
    .ret_bank_i    ( ret_bank      ),
    .rdata_o       ( rd_rdata      )
  );

  read_latency_tracker i_read_latency_tracker (
    .clk_i,
    .rst_n_i,
    .grant_i  ( rd_gnt      ),
    .bank_i   ( rd_gnt_bank ),
    .rvalid_o ( rd_rvalid   ),
    .bank_o   ( ret_bank    )
  );

  for (genvar b = 0; b < `MB_NUM_BANKS; b++) begin : gen_bank
    sram_bank i_sram_bank (
      .clk_i,
      .en_i    ( bank_en[b]    ),
      .we_i    ( bank_we[b]    ),
      .row_i   ( bank_row[b]   ),
      .wdata_i ( bank_wdata[b] ),
      .strb_i  ( bank_strb[b]  ),
      .rdata_o ( bank_rdata[b] )
    );
  end

endmodule

`default_nettype wire

// ==== bench/mem_banked_properties.sv ====
// Bound into each port controller; sees one port only, so bank-side sharing is not checked here
`timescale 1ns/1ns
`default_nettype none

module mem_banked_properties (
  input logic                       clk_i,
  input logic                       rst_n_i,
  input mem_bank_pkg::port_state_e  state_i,
  input logic                       req_ready_i,
  input mem_bus_pkg::bus_rrsp_t     rsp_i,
  input logic                       rsp_valid_i,
  input logic                       rsp_ready_i,
  input mem_bank_pkg::bank_req_t    bank_req_i,
  input logic                       bank_valid_i,
  input logic                       gnt_i
);
  import mem_bank_pkg::*;

  // Response held valid and unchanged until taken
  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else $error("response changed or dropped before it was taken");

  // Response never raised straight from idle
  // A write follows its grant, a read follows its data wait
  a_rsp_after_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(rsp_valid_i) |->
      $past(bank_valid_i && gnt_i && bank_req_i.we) || $past(state_i == st_wait_data))
    else $error("response raised without a bank access before it");

  // Loser of arbitration keeps the same request up
  a_bank_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bank_valid_i && !gnt_i |=> bank_valid_i && $stable(bank_req_i))
    else $error("bank request dropped or changed before its grant");

endmodule

`default_nettype wire

// ==== bench/mem_banked_tb.sv ====
// Word-aligned addresses only; a read never targets a word whose write is still in flight
`timescale 1ns/1ns
`default_nettype none

`include "mem_banked_consts.svh"

module mem_banked_tb;
  import mem_bus_pkg::*;

  localparam int pool_words = 16;
  localparam int rand_rounds = 40;
  localparam int bp_rounds = 30;
  // Directed, partial strobe, preload, then two ops per random round
  localparam int num_txn = 2 + 20 + pool_words + 2 * rand_rounds + 2 * bp_rounds;
  localparam int timeout_cycles = num_txn * 40;

  logic       clk;
  logic       rst_n;
  bus_wreq_t  wreq;
  logic       wreq_valid;
  logic       wreq_ready;
  bus_wrsp_t  wrsp;
  logic       wrsp_valid;
  logic       wrsp_ready;
  bus_rreq_t  rreq;
  logic       rreq_valid;
  logic       rreq_ready;
  bus_rrsp_t  rrsp;
  logic       rrsp_valid;
  logic       rrsp_ready;
  logic [1:0] busy;

  integer     seed;
  logic       bp_en;
  string      test_name;
  // Byte image of what the banks should hold
  logic [7:0] ref_mem [2**`MB_ADDR_W];
  // Expected responses in issue order per port
  bus_wrsp_t  exp_wq[$];
  bus_rrsp_t  exp_rq[$];

  mem_banked_top i_dut (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .wreq_i       ( wreq       ),
    .wreq_valid_i ( wreq_valid ),
    .wreq_ready_o ( wreq_ready ),
    .wrsp_o       ( wrsp       ),
    .wrsp_valid_o ( wrsp_valid ),
    .wrsp_ready_i ( wrsp_ready ),
    .rreq_i       ( rreq       ),
    .rreq_valid_i ( rreq_valid ),
    .rreq_ready_o ( rreq_ready ),
    .rrsp_o       ( rrsp       ),
    .rrsp_valid_o ( rrsp_valid ),
    .rrsp_ready_i ( rrsp_ready ),
    .busy_o       ( busy       )
  );

  // Handshake properties on both port controllers
  bind bus_port_ctrl mem_banked_properties i_properties (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .state_i      ( state_q      ),
    .req_ready_i  ( req_ready_o  ),
    .rsp_i        ( rsp_o        ),
    .rsp_valid_i  ( rsp_valid_o  ),
    .rsp_ready_i  ( rsp_ready_i  ),
    .bank_req_i   ( bank_req_o   ),
    .bank_valid_i ( bank_valid_o ),
    .gnt_i        ( gnt_i        )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_level(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s %s: expected %b, actual %b",
                               test_name, what, exp, act));
    end
  endtask

  task automatic check_wrsp(input bus_wrsp_t exp, input bus_wrsp_t act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s write response: expected id %h, actual id %h",
                               test_name, exp.id, act.id));
    end
  endtask

  task automatic check_rrsp(input bus_rrsp_t exp, input bus_rrsp_t act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s read response: expected %h/%h, actual %h/%h",
                               test_name, exp.id, exp.data, act.id, act.data));
    end
  endtask

  // Strobed bytes land in the image
  task automatic ref_write(input logic [`MB_ADDR_W-1:0] addr,
                           input logic [`MB_DATA_W-1:0] data,
                           input logic [`MB_STRB_W-1:0] strb);
    logic [`MB_ADDR_W-1:0] a;
    for (int i = 0; i < `MB_STRB_W; i++) begin
      a = addr + i[`MB_ADDR_W-1:0];
      if (strb[i]) begin
        ref_mem[a] = data[8*i +: 8];
      end
    end
  endtask

  // Expected read word, little-endian from the byte image
  function automatic logic [`MB_DATA_W-1:0] ref_read(input logic [`MB_ADDR_W-1:0] addr);
    logic [`MB_DATA_W-1:0] word;
    logic [`MB_ADDR_W-1:0] a;
    word = '0;
    for (int i = 0; i < `MB_STRB_W; i++) begin
      a = addr + i[`MB_ADDR_W-1:0];
      word[8*i +: 8] = ref_mem[a];
    end
    return word;
  endfunction

  // Entered and left 1 ns after a rising edge
  task automatic do_write(input logic [`MB_ADDR_W-1:0] addr, input logic [`MB_ID_W-1:0] id,
                          input logic [`MB_DATA_W-1:0] data, input logic [`MB_STRB_W-1:0] strb);
    bus_wrsp_t exp;
    exp.id = id;
    exp_wq.push_back(exp);
    ref_write(addr, data, strb);
    wreq = '{addr: addr, id: id, data: data, strb: strb};
    wreq_valid = 1'b1;
    @(negedge clk);
    while (!wreq_ready) @(negedge clk);
    @(posedge clk);
    #1;
    wreq_valid = 1'b0;
    // Scramble payload so a live-bus bug shows
    wreq.addr = ~addr;
    wreq.id = ~id;
    wreq.data = ~data;
    wreq.strb = ~strb;
    @(negedge clk);
    while (!(wrsp_valid && wrsp_ready)) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic do_read(input logic [`MB_ADDR_W-1:0] addr, input logic [`MB_ID_W-1:0] id);
    bus_rrsp_t exp;
    exp.id = id;
    exp.data = ref_read(addr);
    exp_rq.push_back(exp);
    rreq = '{addr: addr, id: id};
    rreq_valid = 1'b1;
    @(negedge clk);
    while (!rreq_ready) @(negedge clk);
    @(posedge clk);
    #1;
    rreq_valid = 1'b0;
    rreq.addr = ~addr;
    rreq.id = ~id;
    @(negedge clk);
    while (!(rrsp_valid && rrsp_ready)) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  // One write and one read issued together on the pool
  task automatic run_rounds(input int rounds);
    logic [31:0]           rnd;
    logic [31:0]           data;
    logic [3:0]            ri;
    logic [3:0]            wi;
    logic [`MB_ADDR_W-1:0] ra;
    logic [`MB_ADDR_W-1:0] wa;
    for (int n = 0; n < rounds; n++) begin
      rnd = $random(seed);
      data = $random(seed);
      ri = rnd[3:0];
      // Plus 4 keeps the bank and changes the row, plus 1 or 2 changes the bank
      wi = rnd[4] ? ri + 4'd4 : ri + (rnd[5] ? 4'd1 : 4'd2);
      ra = {2'b01, 4'h0, ri, 2'b00};
      wa = {2'b01, 4'h0, wi, 2'b00};
      fork
        do_write(wa, rnd[11:8], data, rnd[15:12]);
        do_read(ra, rnd[19:16]);
      join
    end
  endtask

  // Response ready, low in random stretches under back-pressure
  initial begin
    logic [31:0] rnd;
    wrsp_ready = 1'b1;
    rrsp_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      rnd = $random(seed);
      wrsp_ready = !bp_en || (rnd[1:0] == 2'b00);
      rrsp_ready = !bp_en || (rnd[3:2] == 2'b00);
    end
  end

  // Compare on the falling edge, one check per handshake
  always @(negedge clk) begin
    if (rst_n && wrsp_valid && wrsp_ready) begin
      if (exp_wq.size() == 0) begin
        report_failure("write response arrived with no write outstanding");
      end else begin
        check_wrsp(exp_wq.pop_front(), wrsp);
      end
    end
    if (rst_n && rrsp_valid && rrsp_ready) begin
      if (exp_rq.size() == 0) begin
        report_failure("read response arrived with no read outstanding");
      end else begin
        check_rrsp(exp_rq.pop_front(), rrsp);
      end
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    report_failure($sformatf("timeout after %0d cycles, transactions did not complete",
                             timeout_cycles));
  end

  initial begin
    logic [31:0]           rnd;
    logic [31:0]           data;
    logic [`MB_ADDR_W-1:0] wa;
    seed = 32'h64a8_3001;
    bp_en = 1'b0;
    rst_n = 1'b0;
    wreq = '0;
    wreq_valid = 1'b0;
    rreq = '0;
    rreq_valid = 1'b0;
    test_name = "reset";
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_level("write request ready", 1'b1, wreq_ready);
    check_level("read request ready", 1'b1, rreq_ready);
    check_level("write response valid", 1'b0, wrsp_valid);
    check_level("read response valid", 1'b0, rrsp_valid);
    check_level("write port busy", 1'b0, busy[0]);
    check_level("read port busy", 1'b0, busy[1]);

    test_name = "full_word";
    do_write(12'h040, 4'h3, 32'ha5a5_1234, 4'hf);
    do_read(12'h040, 4'h5);

    // Full word first, then three random strobe merges
    test_name = "partial_strobe";
    for (int i = 0; i < 4; i++) begin
      wa = {2'b10, i[7:0], 2'b00};
      rnd = $random(seed);
      data = $random(seed);
      do_write(wa, rnd[3:0], data, 4'hf);
      for (int k = 0; k < 3; k++) begin
        rnd = $random(seed);
        data = $random(seed);
        do_write(wa, rnd[7:4], data, rnd[11:8]);
      end
      do_read(wa, rnd[15:12]);
    end

    test_name = "preload";
    for (int i = 0; i < pool_words; i++) begin
      data = $random(seed);
      do_write({2'b01, 4'h0, i[3:0], 2'b00}, i[3:0], data, 4'hf);
    end

    test_name = "concurrent";
    run_rounds(rand_rounds);

    test_name = "backpressure";
    bp_en = 1'b1;
    run_rounds(bp_rounds);
    bp_en = 1'b0;

    repeat (4) @(posedge clk);
    #1;
    test_name = "drain";
    check_level("write port busy", 1'b0, busy[0]);
    check_level("read port busy", 1'b0, busy[1]);
    if (exp_wq.size() != 0 || exp_rq.size() != 0) begin
      report_failure("responses still missing at end of run");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/mem_bus_pkg.sv
hw/mem_bank_pkg.sv
hw/bus_port_ctrl.sv
hw/read_latency_tracker.sv
hw/bank_xbar.sv
hw/sram_bank.sv
hw/mem_banked_top.sv
bench/mem_banked_properties.sv
bench/mem_banked_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; the exit status is the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module mem_banked_tb \
  -Mdir obj_dir

./obj_dir/Vmem_banked_tb
